//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --Wno-fatal
TOP      = tbOr1420Fabric
FILELIST = or1420Fabric.f
BUILDDIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --Mdir $(BUILDDIR) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILDDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(BUILDDIR)

//--- busArbiter.sv
`timescale 1ns/100ps
`default_nettype none

module busArbiter import busPkg::*; (
  input  logic           s_systemClock,
  input  logic           s_pllLocked,
  input  logic           systemReset,
  input  busMasterVector busRequests,
  input  logic           beginTransaction,
  input  logic           endTransaction,
  output busMasterVector busGrants,
  output logic           busError
);

  arbiterState     s_stateReg, s_stateNext;
  busMasterVector  s_grantReg, s_grantNext;
  arbWatchdogCount s_watchdogReg, s_watchdogNext;
  busMasterIndex   s_winner;
  logic            s_errorReg, s_errorNext;

  // ##########################################################################
  // Fixed priority select

  always_comb begin
    s_winner = masterDebug;
    for (int i = 0; i < NUM_BUS_MASTERS; i++) begin
      if (busRequests[i]) begin
        s_winner = busMasterIndex'(i);  // Later hit is higher priority
      end
    end
  end

  // ##########################################################################
  // Grant state machine

  always_comb begin
    s_stateNext    = s_stateReg;
    s_grantNext    = s_grantReg;
    s_watchdogNext = s_watchdogReg;
    s_errorNext    = 1'b0;
    case (s_stateReg)
      arbIdle: begin
        if (|busRequests) begin
          s_stateNext    = arbGranted;
          s_grantNext    = busMasterVector'(1) << s_winner;
          s_watchdogNext = arbWatchdogCount'(ARB_GRANT_TIMEOUT - 1);
        end
      end
      arbGranted: begin
        if (beginTransaction) begin
          s_stateNext = arbTransfer;
        end else if (s_watchdogReg == '0) begin
          s_stateNext = arbIdle;  // Master never started
          s_grantNext = '0;
          s_errorNext = 1'b1;
        end else begin
          s_watchdogNext = s_watchdogReg - 1'b1;
        end
      end
      arbTransfer: begin
        if (endTransaction) begin
          s_stateNext = arbIdle;
          s_grantNext = '0;
        end
      end
      default: begin
        s_stateNext = arbIdle;
        s_grantNext = '0;
      end
    endcase
  end

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      s_stateReg    <= arbIdle;
      s_grantReg    <= '0;
      s_watchdogReg <= '0;
      s_errorReg    <= 1'b0;
    end else if (systemReset) begin
      s_stateReg    <= arbIdle;
      s_grantReg    <= '0;
      s_watchdogReg <= '0;
      s_errorReg    <= 1'b0;
    end else begin
      s_stateReg    <= s_stateNext;
      s_grantReg    <= s_grantNext;
      s_watchdogReg <= s_watchdogNext;
      s_errorReg    <= s_errorNext;
    end
  end

  assign busGrants = s_grantReg;
  assign busError  = s_errorReg;  // One cycle per timeout

endmodule

`default_nettype wire

//--- busPkg.sv
`default_nettype none

package busPkg;

  localparam int NUM_BUS_MASTERS    = 5;
  localparam int ARB_GRANT_TIMEOUT  = 16;  // Cycles allowed before a begin
  localparam int ARB_WATCHDOG_WIDTH = $clog2(ARB_GRANT_TIMEOUT);

  // Request and grant bit positions, higher index wins
  typedef enum logic [2:0] {
    masterDebug   = 3'd0,
    masterCamera  = 3'd1,
    masterDisplay = 3'd2,
    masterIcache  = 3'd3,
    masterDcache  = 3'd4
  } busMasterIndex;

  typedef logic [NUM_BUS_MASTERS-1:0]    busMasterVector;
  typedef logic [ARB_WATCHDOG_WIDTH-1:0] arbWatchdogCount;

  typedef enum logic [1:0] {
    arbIdle,
    arbGranted,   // Waiting for begin of transaction
    arbTransfer   // Waiting for end of transaction
  } arbiterState;

endpackage

`default_nettype wire

//--- ciDelayTimer.sv
`timescale 1ns/100ps
`default_nettype none

module ciDelayTimer import ciPkg::*; (
  input  logic  s_systemClock,
  input  logic  s_pllLocked,
  input  logic  systemReset,
  input  logic  delayStart,
  input  ciWord delayMicroseconds,
  output logic  delayDone,
  output logic  delayBusy
);

  ciWord        s_microCountReg;
  prescaleCount s_prescaleReg;
  logic         s_zeroDelay;

  assign s_zeroDelay = (delayMicroseconds == '0);

  // Prescaler divides the system clock down to one microsecond
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      s_microCountReg <= '0;
      s_prescaleReg   <= '0;
    end else if (systemReset) begin
      s_microCountReg <= '0;
      s_prescaleReg   <= '0;
    end else if (delayStart) begin
      // Zero delay still completes after a single cycle
      s_microCountReg <= s_zeroDelay ? ciWord'(1) : delayMicroseconds;
      s_prescaleReg   <= s_zeroDelay ? prescaleCount'(0) : PRESCALE_RELOAD;
    end else if (delayBusy) begin
      if (s_prescaleReg == '0) begin
        s_microCountReg <= s_microCountReg - 1'b1;  // One microsecond elapsed
        s_prescaleReg   <= PRESCALE_RELOAD;
      end else begin
        s_prescaleReg <= s_prescaleReg - 1'b1;
      end
    end
  end

  assign delayBusy = (s_microCountReg != '0);
  assign delayDone = (s_microCountReg == ciWord'(1)) && (s_prescaleReg == '0);  // Last cycle

endmodule

`default_nettype wire

//--- ciDispatch.sv
`timescale 1ns/100ps
`default_nettype none

module ciDispatch import ciPkg::*; (
  input  ciRequest  ciIn,
  input  logic      delayDone,
  input  logic      delayBusy,
  output logic      delayStart,
  output ciWord     delayMicroseconds,
  output ciResponse ciOut
);

  logic  s_accept;
  logic  s_swapSelect;
  ciWord s_swapResult;

  assign s_accept          = ciIn.start & ~delayBusy;  // Ignored while delay runs
  assign s_swapSelect      = s_accept && (ciIn.number == CI_SWAP_BYTE);
  assign delayStart        = s_accept && (ciIn.number == CI_DELAY_MICRO);
  assign delayMicroseconds = ciIn.dataA;

  always_comb begin
    if (ciIn.dataB[0]) begin
      // Swap within each half
      s_swapResult = {ciIn.dataA[23:16], ciIn.dataA[31:24],
                      ciIn.dataA[7:0], ciIn.dataA[15:8]};
    end else begin
      s_swapResult = {ciIn.dataA[7:0], ciIn.dataA[15:8],
                      ciIn.dataA[23:16], ciIn.dataA[31:24]};  // Full reverse
    end
  end

  // ##########################################################################
  // Response merge, result stays zero without done

  always_comb begin
    ciOut.done   = s_swapSelect | delayDone;
    ciOut.result = s_swapSelect ? s_swapResult : '0;  // Delay returns zero
  end

endmodule

`default_nettype wire

//--- ciPkg.sv
`default_nettype none

package ciPkg;

  typedef logic [7:0]  ciNumber;
  typedef logic [31:0] ciWord;

  localparam ciNumber CI_SWAP_BYTE   = 8'd1;
  localparam ciNumber CI_DELAY_MICRO = 8'd6;

  localparam int SYSTEM_CLOCK_MHZ  = 25;
  localparam int PRESCALE_WIDTH    = $clog2(SYSTEM_CLOCK_MHZ);
  localparam int RESET_COUNT_WIDTH = 5;

  typedef logic [PRESCALE_WIDTH-1:0]    prescaleCount;
  typedef logic [RESET_COUNT_WIDTH-1:0] resetCount;

  localparam prescaleCount PRESCALE_RELOAD = prescaleCount'(SYSTEM_CLOCK_MHZ - 1);

  typedef struct packed {
    ciNumber number;
    ciWord   dataA;
    ciWord   dataB;
    logic    start;
  } ciRequest;

  typedef struct packed {
    logic  done;
    ciWord result;
  } ciResponse;

endpackage

`default_nettype wire

//--- or1420Fabric.f
busPkg.sv
ciPkg.sv
resetSequencer.sv
busArbiter.sv
ciDelayTimer.sv
ciDispatch.sv
or1420Fabric.sv
tbOr1420Fabric.sv

//--- or1420Fabric.sv
`timescale 1ns/100ps
`default_nettype none

module or1420Fabric import busPkg::*, ciPkg::*; (
  input  logic           s_systemClock,
  input  logic           s_pllLocked,
  input  busMasterVector busRequests,
  input  logic           beginTransaction,
  input  logic           endTransaction,
  input  ciRequest       ciIn,
  output logic           cpuReset,
  output busMasterVector busGrants,
  output logic           busError,
  output ciResponse      ciOut
);

  logic  s_delayStart;
  logic  s_delayDone;
  logic  s_delayBusy;
  ciWord s_delayMicroseconds;

  // ##########################################################################
  // Reset and bus arbitration

  resetSequencer resetSeq (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .systemReset   (cpuReset)  // Also the fabric reset
  );

  busArbiter arbiter (
    .s_systemClock    (s_systemClock),
    .s_pllLocked      (s_pllLocked),
    .systemReset      (cpuReset),
    .busRequests      (busRequests),
    .beginTransaction (beginTransaction),
    .endTransaction   (endTransaction),
    .busGrants        (busGrants),
    .busError         (busError)
  );

  // ##########################################################################
  // Custom instructions

  ciDispatch dispatch (
    .ciIn              (ciIn),
    .delayDone         (s_delayDone),
    .delayBusy         (s_delayBusy),
    .delayStart        (s_delayStart),
    .delayMicroseconds (s_delayMicroseconds),
    .ciOut             (ciOut)
  );

  ciDelayTimer delayMicro (
    .s_systemClock     (s_systemClock),
    .s_pllLocked       (s_pllLocked),
    .systemReset       (cpuReset),
    .delayStart        (s_delayStart),
    .delayMicroseconds (s_delayMicroseconds),
    .delayDone         (s_delayDone),
    .delayBusy         (s_delayBusy)
  );

endmodule

`default_nettype wire

//--- resetSequencer.sv
`timescale 1ns/100ps
`default_nettype none

module resetSequencer import ciPkg::*; (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic systemReset
);

  resetCount s_resetCountReg;

  // Counts from lock until the top bit sets, then holds there
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      s_resetCountReg <= '0;
    end else if (!s_resetCountReg[RESET_COUNT_WIDTH-1]) begin
      s_resetCountReg <= s_resetCountReg + 1'b1;
    end
  end

  assign systemReset = ~s_resetCountReg[RESET_COUNT_WIDTH-1];  // High until count done

endmodule

`default_nettype wire

//--- tbOr1420Fabric.sv
`timescale 1ns/100ps
`default_nettype none

module tbOr1420Fabric import busPkg::*, ciPkg::*; ();

  logic           s_systemClock = 1'b0;
  logic           s_pllLocked;
  busMasterVector busRequests;
  logic           beginTransaction;
  logic           endTransaction;
  ciRequest       ciIn;
  logic           cpuReset;
  busMasterVector busGrants;
  logic           busError;
  ciResponse      ciOut;

  int          errorCount  = 0;
  int          testCount   = 0;
  int          failedTests = 0;
  logic [31:0] lfsrState   = 32'h410a;

  or1420Fabric i_dut (.*);

  initial begin
    forever #20 s_systemClock = ~s_systemClock;  // 40 ns period
  end

  // ##########################################################################
  // Reporting and checks

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, expected, actual);
      errorCount++;
    end
  endtask

  task automatic checkTimeout(input logic expired, input string what);
    assert (!expired) else begin
      $display("Timed out at %0t ns while waiting for %s", $time, what);
      errorCount++;
    end
  endtask

  task automatic reportTest(input string name, input int errorsBefore);
    testCount++;
    if (errorCount == errorsBefore) begin
      $display("test %0d %s ok", testCount, name);
    end else begin
      failedTests++;
      $display("test %0d %s failed", testCount, name);
    end
  endtask

  // Taps 32 22 2 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic takeBits(input int count, output logic [31:0] bits);
    bits = '0;
    repeat (count) begin
      lfsrState = lfsrNext(lfsrState);
      bits      = {bits[30:0], lfsrState[0]};
    end
  endtask

  function automatic ciWord swapModel(input ciWord value, input logic halfMode);
    ciWord swapped;
    for (int k = 0; k < 4; k++) begin
      if (halfMode) swapped[8*(k^1) +: 8] = value[8*k +: 8];  // Neighbour byte
      else swapped[8*(3-k) +: 8] = value[8*k +: 8];           // Mirror byte
    end
    return swapped;
  endfunction

  // ##########################################################################
  // Test sequences, driven on the falling edge and sampled 10 ns later

  task automatic runSwap(input ciNumber num, input ciWord opA, input ciWord opB,
                         input logic expDone, input ciWord expResult);
    @(negedge s_systemClock);
    ciIn.number = num;
    ciIn.dataA  = opA;
    ciIn.dataB  = opB;
    ciIn.start  = 1'b1;
    #10;
    checkValue("ciOut.done", 32'(expDone), 32'(ciOut.done));
    checkValue("ciOut.result", expResult, ciOut.result);
    if (!expDone) begin
      repeat (3) begin  // Unknown number held, stays silent
        @(negedge s_systemClock);
        #10;
        checkValue("ciOut.done", 0, 32'(ciOut.done));
      end
    end
    @(negedge s_systemClock);
    ciIn.start = 1'b0;
  endtask

  task automatic runDelay(input ciWord micro, input int expCycles, input ciWord expResult);
    int cycles;
    @(negedge s_systemClock);
    ciIn.number = CI_DELAY_MICRO;
    ciIn.dataA  = micro;
    ciIn.dataB  = '0;
    ciIn.start  = 1'b1;
    #10;
    checkValue("ciOut.done", 0, 32'(ciOut.done));
    cycles = 0;
    do begin
      @(negedge s_systemClock);
      ciIn.start = 1'b0;
      #10;
      cycles++;
    end while (!ciOut.done && cycles < 4000);
    checkTimeout(!ciOut.done, "delay done");
    checkValue("delay cycles", expCycles, cycles);
    checkValue("ciOut.result", expResult, ciOut.result);
    @(negedge s_systemClock);
    #10;
    checkValue("ciOut.done", 0, 32'(ciOut.done));  // Single pulse
  endtask

  task automatic releaseGrant();
    @(negedge s_systemClock);
    busRequests      = '0;
    beginTransaction = 1'b1;
    @(negedge s_systemClock);
    beginTransaction = 1'b0;
    endTransaction   = 1'b1;
    @(negedge s_systemClock);
    endTransaction = 1'b0;
    #10;
    checkValue("busGrants", 0, 32'(busGrants));
  endtask

  task automatic runPriority(input busMasterVector requests, input busMasterVector expFirst,
                             input busMasterVector expSecond);
    @(negedge s_systemClock);
    busRequests = requests;
    #10;
    checkValue("busGrants", 0, 32'(busGrants));
    @(negedge s_systemClock);
    #10;
    checkValue("busGrants", 32'(expFirst), 32'(busGrants));
    @(negedge s_systemClock);
    beginTransaction = 1'b1;
    @(negedge s_systemClock);
    beginTransaction = 1'b0;
    endTransaction   = 1'b1;
    busRequests      = requests & ~expFirst;  // Served master leaves
    @(negedge s_systemClock);
    endTransaction = 1'b0;
    #10;
    checkValue("busGrants", 0, 32'(busGrants));
    @(negedge s_systemClock);
    #10;
    checkValue("busGrants", 32'(expSecond), 32'(busGrants));
    releaseGrant();
  endtask

  task automatic runWatchdog(input busMasterVector requests, input int expTimeout,
                             input busMasterVector expGrant);
    int cycles;
    @(negedge s_systemClock);
    busRequests = requests;
    @(negedge s_systemClock);
    #10;
    checkValue("busGrants", 32'(expGrant), 32'(busGrants));
    cycles = 0;
    do begin
      @(negedge s_systemClock);
      #10;
      cycles++;
      if (busGrants == expGrant) begin
        checkValue("busError", 0, 32'(busError));  // Quiet while grant held
      end
    end while (busGrants == expGrant && cycles < 40);
    checkTimeout(busGrants == expGrant, "grant withdrawal");
    checkValue("watchdog cycles", expTimeout, cycles);
    checkValue("busError", 1, 32'(busError));
    @(negedge s_systemClock);
    #10;
    checkValue("busError", 0, 32'(busError));
    checkValue("busGrants", 32'(expGrant), 32'(busGrants));  // Arbitration resumes
    releaseGrant();
  endtask

  // ##########################################################################
  // Main sequence

  initial begin
    int          fd;
    int          fields;
    int          cycles;
    int          errorsBefore;
    string       line;
    logic [31:0] kind, num, opA, opB, exp0, exp1;
    logic [31:0] randA, randMode;
    s_pllLocked      = 1'b0;
    busRequests      = '0;
    beginTransaction = 1'b0;
    endTransaction   = 1'b0;
    ciIn             = '0;

    errorsBefore = errorCount;
    repeat (5) begin
      @(negedge s_systemClock);
      #10;
      checkValue("cpuReset", 1, 32'(cpuReset));
      checkValue("busGrants", 0, 32'(busGrants));
      checkValue("ciOut.done", 0, 32'(ciOut.done));
    end
    @(negedge s_systemClock);
    s_pllLocked = 1'b1;
    #10;
    cycles = 0;
    while (cpuReset && cycles < 40) begin
      @(negedge s_systemClock);
      #10;
      cycles++;
    end
    checkTimeout(cpuReset, "cpuReset release");
    checkValue("reset release cycles", 16, cycles);
    reportTest("reset", errorsBefore);

    fd = $fopen("tbOr1420FabricInput.txt", "r");
    assert (fd != 0) else begin
      $display("Could not open tbOr1420FabricInput.txt");
      errorCount++;
    end
    while (fd != 0 && $fgets(line, fd) != 0) begin
      fields = $sscanf(line, "%h %h %h %h %h %h", kind, num, opA, opB, exp0, exp1);
      if (fields == 6) begin  // Comment and blank lines fall through
        errorsBefore = errorCount;
        case (kind)
          0: runSwap(ciNumber'(num), opA, opB, exp0[0], exp1);
          1: runDelay(opA, exp0, exp1);
          2: runPriority(busMasterVector'(opA), busMasterVector'(exp0), busMasterVector'(exp1));
          3: runWatchdog(busMasterVector'(opA), exp0, busMasterVector'(exp1));
          default: begin
            $display("Vector with unknown test kind %0d", kind);
            errorCount++;
          end
        endcase
        reportTest($sformatf("vector kind %0d operand %h", kind, opA), errorsBefore);
      end
    end
    if (fd != 0) $fclose(fd);

    repeat (8) begin
      takeBits(32, randA);
      takeBits(1, randMode);
      errorsBefore = errorCount;
      runSwap(CI_SWAP_BYTE, randA, {31'd0, randMode[0]}, 1'b1, swapModel(randA, randMode[0]));
      reportTest($sformatf("random swap %h mode %0d", randA, randMode[0]), errorsBefore);
    end

    $display("%0d tests, %0d failed, %0d errors", testCount, failedTests, errorCount);
    if (errorCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tbOr1420FabricInput.txt
# kind number dataA dataB expect0 expect1, all hex
# kind 0 swap (done, result), 1 delay (cycles, result), 2 priority (grant, next), 3 watchdog (edges, grant)
0 01 12345678 00000000 1 78563412
0 01 12345678 00000001 1 34127856
0 01 deadbeef 00000000 1 efbeadde
0 01 deadbeef 00000001 1 addeefbe
0 01 000000ff 00000000 1 ff000000
0 01 a1b2c3d4 00000001 1 b2a1d4c3
0 03 12345678 00000000 0 00000000
0 00 12345678 00000000 0 00000000
1 06 00000000 00000000 1 00000000
1 06 00000001 00000000 19 00000000
1 06 00000003 00000000 4b 00000000
2 00 0000001f 00000000 10 08
2 00 00000016 00000000 10 04
2 00 0000000c 00000000 08 04
2 00 00000003 00000000 02 01
3 00 00000004 00000000 10 04
3 00 00000011 00000000 10 10
